//--- design/ppu_pkg.sv
`default_nettype none

package ppu_pkg;

  // Raster geometry, counted in pixel strobes
  localparam logic [8:0] dots_per_line   = 9'd341;
  localparam logic [8:0] lines_per_frame = 9'd262;
  localparam logic [8:0] visible_width   = 9'd256;  // x 1 to 256
  localparam logic [8:0] visible_height  = 9'd240;
  localparam logic [8:0] hsync_start     = 9'd275;
  localparam logic [8:0] hsync_end       = 9'd300;
  localparam logic [8:0] vsync_start     = 9'd242;
  localparam logic [8:0] vsync_end       = 9'd244;
  localparam logic [8:0] vblank_line     = 9'd241;
  localparam logic [8:0] prerender_line  = 9'd261;

  // Host register numbers
  localparam logic [2:0] reg_control  = 3'd0;
  localparam logic [2:0] reg_mask     = 3'd1;
  localparam logic [2:0] reg_status   = 3'd2;
  localparam logic [2:0] reg_oam_addr = 3'd3;
  localparam logic [2:0] reg_oam_data = 3'd4;
  localparam logic [2:0] reg_scroll   = 3'd5;
  localparam logic [2:0] reg_addr     = 3'd6;
  localparam logic [2:0] reg_data     = 3'd7;

  localparam int ctrl_nmi_bit  = 7;
  localparam int ctrl_incr_bit = 2;  // 0 steps by 1, 1 steps by 32

  // v[13:8] all ones selects the palette
  localparam logic [5:0] palette_page = 6'h3F;

  localparam int addr_width    = 14;
  localparam int scroll_width  = 15;
  localparam int palette_depth = 32;
  localparam int palette_width = 6;
  localparam int color_count   = 64;

  // Power-up palette, entry 0 is the backdrop
  localparam logic [palette_width-1:0] palette_init [palette_depth] = '{
    6'h0F, 6'h01, 6'h11, 6'h21, 6'h0F, 6'h06, 6'h16, 6'h26,
    6'h0F, 6'h09, 6'h19, 6'h29, 6'h0F, 6'h02, 6'h12, 6'h22,
    6'h0F, 6'h14, 6'h24, 6'h34, 6'h0F, 6'h17, 6'h27, 6'h37,
    6'h0F, 6'h1A, 6'h2A, 6'h3A, 6'h0F, 6'h13, 6'h23, 6'h33
  };

endpackage

`default_nettype wire

//--- design/pixel_timing.sv
`default_nettype none

module pixel_timing (
  input  wire        I_clock,
  input  wire        I_reset,
  output logic       vid_clock,
  output logic       pixel_rise,
  output logic [8:0] pos_x,
  output logic [8:0] pos_y,
  output logic       vid_hsync,
  output logic       vid_vsync,
  output logic       vid_visible,
  output logic       vblank_set,
  output logic       vblank_clear
);

  logic [1:0] div;
  logic       last_x;
  logic       last_y;
  logic       line_start;

  assign vid_clock  = ~div[1];      // High on phases 0 and 1
  assign pixel_rise = div == 2'd0;  // Phase where vid_clock goes high

  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
      div <= 2'd0;
    else
      div <= div + 2'd1;
  end

  assign last_x = pos_x == ppu_pkg::dots_per_line - 9'd1;
  assign last_y = pos_y == ppu_pkg::lines_per_frame - 9'd1;

  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
    begin
      pos_x <= 9'd0;
      pos_y <= 9'd0;
    end
    else if (pixel_rise)
    begin
      if (last_x)
      begin
        pos_x <= 9'd0;
        pos_y <= last_y ? 9'd0 : pos_y + 9'd1;
      end
      else
        pos_x <= pos_x + 9'd1;
    end
  end

  // Both syncs active low
  assign vid_hsync = !(pos_x >= ppu_pkg::hsync_start && pos_x <= ppu_pkg::hsync_end);
  assign vid_vsync = !(pos_y >= ppu_pkg::vsync_start && pos_y <= ppu_pkg::vsync_end);

  assign vid_visible = pos_x != 9'd0 && pos_x <= ppu_pkg::visible_width
                       && pos_y < ppu_pkg::visible_height;

  // One pulse per line, at the strobe that ends dot 0
  assign line_start   = pixel_rise && pos_x == 9'd0;
  assign vblank_set   = line_start && pos_y == ppu_pkg::vblank_line;
  assign vblank_clear = line_start && pos_y == ppu_pkg::prerender_line;

endmodule

`default_nettype wire

//--- design/host_regs.sv
`default_nettype none

module host_regs (
  input  wire  [2:0]                          host_addr,
  input  wire                                 I_clock,
  input  wire                                 I_reset,
  input  wire                                 host_rden,
  input  wire                                 host_wren,
  input  wire  [7:0]                          host_wdata,
  output logic [7:0]                          host_rdata,
  output logic                                nmi,
  input  wire                                 pixel_rise,
  input  wire                                 vblank_set,
  input  wire                                 vblank_clear,
  input  wire  [7:0]                          vid_rdata,
  output logic                                vid_wren,
  output logic [ppu_pkg::addr_width-1:0]      vram_addr,
  output logic                                palette_wren,
  input  wire  [ppu_pkg::palette_width-1:0]   palette_rdata
);

  logic                            last_wren;
  logic                            last_rden;
  logic                            last_status_rd;  // Status read seen last cycle
  logic                            wr_pulse;
  logic                            rd_pulse;
  logic [7:0]                      control;
  logic [7:0]                      mask;
  logic [7:0]                      open_bus;
  logic [7:0]                      read_buf;
  logic [2:0]                      fine_x;
  logic                            toggle;
  logic                            vblank;
  logic [ppu_pkg::scroll_width-1:0] t_reg;
  logic [ppu_pkg::scroll_width-1:0] v_reg;
  logic [ppu_pkg::scroll_width-1:0] v_step;
  logic                            sel_status;
  logic                            sel_data;
  logic                            pal_access;

  assign sel_status = host_addr == ppu_pkg::reg_status;
  assign sel_data   = host_addr == ppu_pkg::reg_data;
  assign pal_access = v_reg[13:8] == ppu_pkg::palette_page;
  assign v_step     = control[ppu_pkg::ctrl_incr_bit] ? 15'd32 : 15'd1;

  assign vram_addr    = v_reg[ppu_pkg::addr_width-1:0];  // Top bit of v dropped
  assign vid_wren     = host_wren & sel_data & ~pal_access;
  assign palette_wren = wr_pulse & sel_data & pal_access;
  assign nmi          = ~(control[ppu_pkg::ctrl_nmi_bit] & vblank);

  // Strobe edges, delayed one cycle so writes land after first sample
  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
    begin
      last_wren      <= 1'b0;
      last_rden      <= 1'b0;
      wr_pulse       <= 1'b0;
      rd_pulse       <= 1'b0;
      last_status_rd <= 1'b0;
    end
    else
    begin
      last_wren      <= host_wren;
      last_rden      <= host_rden;
      wr_pulse       <= host_wren & ~last_wren;
      rd_pulse       <= host_rden & ~last_rden;
      last_status_rd <= host_rden & sel_status;
    end
  end

  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
    begin
      control  <= 8'd0;
      mask     <= 8'd0;
      open_bus <= 8'd0;
      read_buf <= 8'd0;
      fine_x   <= 3'd0;
      toggle   <= 1'b0;
      t_reg    <= '0;
      v_reg    <= '0;
    end
    else
    begin
      if (host_rden && sel_data)
        read_buf <= vid_rdata;  // Refilled for the whole strobe
      if (rd_pulse && sel_status)
        toggle <= 1'b0;
      if (rd_pulse && sel_data)
        v_reg <= v_reg + v_step;

      if (wr_pulse)
      begin
        open_bus <= host_wdata;
        case (host_addr)
          ppu_pkg::reg_control:
          begin
            control      <= host_wdata;
            t_reg[11:10] <= host_wdata[1:0];  // Nametable select
          end
          ppu_pkg::reg_mask:
            mask <= host_wdata;
          ppu_pkg::reg_scroll:
          begin
            toggle <= ~toggle;
            if (!toggle)
            begin
              t_reg[4:0] <= host_wdata[7:3];  // Coarse x
              fine_x     <= host_wdata[2:0];
            end
            else
            begin
              t_reg[9:5]   <= host_wdata[7:3];  // Coarse y
              t_reg[14:12] <= host_wdata[2:0];  // Fine y
            end
          end
          ppu_pkg::reg_addr:
          begin
            toggle <= ~toggle;
            if (!toggle)
              t_reg[14:8] <= {1'b0, host_wdata[5:0]};
            else
            begin
              t_reg[7:0] <= host_wdata;
              v_reg      <= {t_reg[14:8], host_wdata};
            end
          end
          ppu_pkg::reg_data:
            v_reg <= v_reg + v_step;
          ppu_pkg::reg_status, ppu_pkg::reg_oam_addr, ppu_pkg::reg_oam_data: ;
        endcase
      end
    end
  end

  // Vblank flag, read clear first so a same-cycle set still wins
  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
      vblank <= 1'b0;
    else
    begin
      if (last_status_rd && !host_rden)
        vblank <= 1'b0;
      if (pixel_rise)
      begin
        if (vblank_clear)
          vblank <= 1'b0;
        if (vblank_set)
          vblank <= 1'b1;
      end
    end
  end

  always_comb
  begin
    host_rdata = open_bus;
    case (host_addr)
      ppu_pkg::reg_status:
        host_rdata = {vblank, 2'b00, open_bus[4:0]};  // Sprite flags read as zero
      ppu_pkg::reg_data:
      begin
        if (pal_access)
          host_rdata[5:0] = palette_rdata;
        else
          host_rdata = read_buf;  // Value from before this read
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- design/palette_ram.sv
`default_nettype none

module palette_ram (
  input  wire                                I_clock,
  input  wire  [ppu_pkg::addr_width-1:0]     vram_addr,
  input  wire                                palette_wren,
  input  wire  [ppu_pkg::palette_width-1:0]  host_wdata,
  output logic [ppu_pkg::palette_width-1:0]  palette_rdata,
  output logic [ppu_pkg::palette_width-1:0]  backdrop_index
);

  logic [ppu_pkg::palette_width-1:0] entries [ppu_pkg::palette_depth] = ppu_pkg::palette_init;
  logic [4:0]                        index;

  // 0x10, 0x14, 0x18 and 0x1C alias the background entries below them
  always_comb
  begin
    index = vram_addr[4:0];
    if (vram_addr[1:0] == 2'b00)
      index[4] = 1'b0;
  end

  always_ff @(posedge I_clock)
  begin
    if (palette_wren)
      entries[index] <= host_wdata;
    palette_rdata  <= entries[index];
    backdrop_index <= entries[0];  // Every pixel shows the backdrop
  end

endmodule

`default_nettype wire

//--- design/color_table.sv
`default_nettype none

module color_table (
  input  wire  [ppu_pkg::palette_width-1:0] backdrop_index,
  output logic [7:0]                        red,
  output logic [7:0]                        green,
  output logic [7:0]                        blue
);

  // Packed as 8-bit red, green, blue
  localparam logic [23:0] rgb_table [ppu_pkg::color_count] = '{
    24'h545454, 24'h001E74, 24'h081090, 24'h300088,
    24'h440064, 24'h5C0030, 24'h540400, 24'h3C1800,
    24'h202A00, 24'h083A00, 24'h004000, 24'h003C00,
    24'h00323C, 24'h000000, 24'h000000, 24'h000000,
    24'h989698, 24'h084CC4, 24'h3032EC, 24'h5C1EE4,
    24'h8814B0, 24'hA01464, 24'h982220, 24'h783C00,
    24'h545A00, 24'h287200, 24'h087C00, 24'h007628,
    24'h006678, 24'h000000, 24'h000000, 24'h000000,
    24'hECEEEC, 24'h4C9AEC, 24'h787CEC, 24'hB062EC,
    24'hE454EC, 24'hEC58B4, 24'hEC6A64, 24'hD48820,
    24'hA0AA00, 24'h74C400, 24'h4CD020, 24'h38CC6C,
    24'h38B4CC, 24'h3C3C3C, 24'h000000, 24'h000000,
    24'hECEEEC, 24'hA8CCEC, 24'hBCBCEC, 24'hD4B2EC,
    24'hECAEEC, 24'hECAED4, 24'hECB4B0, 24'hE4C490,
    24'hCCD278, 24'hB4DE78, 24'hA8E290, 24'h98E2B4,
    24'hA0D6E4, 24'hA0A2A0, 24'h000000, 24'h000000
  };

  logic [23:0] rgb;

  assign rgb   = rgb_table[backdrop_index];
  assign red   = rgb[23:16];
  assign green = rgb[15:8];
  assign blue  = rgb[7:0];

endmodule

`default_nettype wire

//--- design/video.sv
`default_nettype none

module video (
  input  wire                            I_clock,
  input  wire                            I_reset,
  input  wire  [2:0]                     host_addr,
  input  wire                            host_rden,
  input  wire                            host_wren,
  input  wire  [7:0]                     host_wdata,
  output logic [7:0]                     host_rdata,
  output logic                           nmi,          // Active low
  output logic [ppu_pkg::addr_width-1:0] vid_addr,
  output logic                           vid_wren,
  output logic [7:0]                     vid_wdata,
  input  wire  [7:0]                     vid_rdata,
  output logic                           vid_clock,
  output logic                           vid_rise,
  output logic                           vid_hsync,
  output logic                           vid_vsync,
  output logic                           vid_visible,
  output logic [7:0]                     red,
  output logic [7:0]                     green,
  output logic [7:0]                     blue
);

  logic [8:0]                        pos_x;
  logic [8:0]                        pos_y;
  logic                              vblank_set;
  logic                              vblank_clear;
  logic                              palette_wren;
  logic [ppu_pkg::palette_width-1:0] palette_rdata;
  logic [ppu_pkg::palette_width-1:0] backdrop_index;

  assign vid_wdata = host_wdata;  // Host byte goes straight to video memory

  pixel_timing timing (
    .I_clock      (I_clock),
    .I_reset      (I_reset),
    .vid_clock    (vid_clock),
    .pixel_rise   (vid_rise),
    .pos_x        (pos_x),
    .pos_y        (pos_y),
    .vid_hsync    (vid_hsync),
    .vid_vsync    (vid_vsync),
    .vid_visible  (vid_visible),
    .vblank_set   (vblank_set),
    .vblank_clear (vblank_clear)
  );

  host_regs regs (
    .I_clock       (I_clock),
    .I_reset       (I_reset),
    .host_addr     (host_addr),
    .host_rden     (host_rden),
    .host_wren     (host_wren),
    .host_wdata    (host_wdata),
    .host_rdata    (host_rdata),
    .nmi           (nmi),
    .pixel_rise    (vid_rise),
    .vblank_set    (vblank_set),
    .vblank_clear  (vblank_clear),
    .vid_rdata     (vid_rdata),
    .vid_wren      (vid_wren),
    .vram_addr     (vid_addr),
    .palette_wren  (palette_wren),
    .palette_rdata (palette_rdata)
  );

  palette_ram palette (
    .I_clock        (I_clock),
    .vram_addr      (vid_addr),
    .palette_wren   (palette_wren),
    .host_wdata     (host_wdata[ppu_pkg::palette_width-1:0]),
    .palette_rdata  (palette_rdata),
    .backdrop_index (backdrop_index)
  );

  color_table colors (
    .backdrop_index (backdrop_index),
    .red            (red),
    .green          (green),
    .blue           (blue)
  );

endmodule

`default_nettype wire

//--- testbench/video_chk.sv
`default_nettype none

module video_chk (
  input wire I_clock,
  input wire I_reset,
  input wire vid_rise,
  input wire vid_clock,
  input wire vid_wren,
  input wire host_wren
);

  timeunit 1ns;
  timeprecision 100ps;

  // Pixel strobe is a single-cycle pulse
  rise_single: assert property (@(posedge I_clock) disable iff (!I_reset)
    vid_rise |=> !vid_rise)
    else $error("vid_rise was high on two consecutive cycles");

  rise_on_edge: assert property (@(posedge I_clock) disable iff (!I_reset)
    $rose(vid_clock) |-> vid_rise)
    else $error("vid_clock rose without a vid_rise pulse");

  // Memory write only inside a host write strobe
  wren_in_strobe: assert property (@(posedge I_clock) disable iff (!I_reset)
    vid_wren |-> host_wren)
    else $error("vid_wren was high while host_wren was low");

endmodule

`default_nettype wire

//--- testbench/video_tb.sv
`default_nettype none

module video_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int trace_depth    = 64;
  localparam int timeout_cycles = 5 * 262 * 341 * 4;  // Five full frames

  logic        I_clock = 1'b0;
  logic        I_reset;
  logic [2:0]  host_addr;
  logic        host_rden;
  logic        host_wren;
  logic [7:0]  host_wdata;
  logic [7:0]  host_rdata;
  logic        nmi;
  logic [13:0] vid_addr;
  logic        vid_wren;
  logic [7:0]  vid_wdata;
  logic [7:0]  vid_rdata;
  logic        vid_clock;
  logic        vid_rise;
  logic        vid_hsync;
  logic        vid_vsync;
  logic        vid_visible;
  logic [7:0]  red;
  logic [7:0]  green;
  logic [7:0]  blue;

  // Word layout: op, reg, data, vid_rdata, expected
  logic [47:0] trace [trace_depth];
  int          check_count = 0;
  int          error_count = 0;
  int          cycle_count = 0;

  video UUT (.*);

  bind video video_chk chk (
    .I_clock   (I_clock),
    .I_reset   (I_reset),
    .vid_rise  (vid_rise),
    .vid_clock (vid_clock),
    .vid_wren  (vid_wren),
    .host_wren (host_wren)
  );

  always #2 I_clock = ~I_clock;

  // Limit covers two frames of timing checks plus a vblank wait
  always @(posedge I_clock)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == timeout_cycles)
    begin
      $display("Timeout after %0d cycles, the trace did not finish", cycle_count);
      $display("test failed");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [23:0] got,
                             input logic [23:0] expected);
    check_count++;
    assert (got === expected)
    else
    begin
      error_count++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  // Returns at the first sample with the chosen sync low after high
  task automatic wait_sync_fall(input logic vertical);
    logic prev;
    logic now;
    @(negedge I_clock);
    now = vertical ? vid_vsync : vid_hsync;
    do
    begin
      prev = now;
      @(negedge I_clock);
      now = vertical ? vid_vsync : vid_hsync;
    end while (!(prev && !now));
  endtask

  task automatic measure_timing();
    int   dots;
    int   sync_dots;
    int   lit_dots;
    int   clock_high;
    int   lines;
    logic prev_h;
    logic prev_v;
    dots       = 0;
    sync_dots  = 0;
    lit_dots   = 0;
    clock_high = 0;
    lines      = 0;
    wait_sync_fall(1'b0);
    do
    begin
      dots       += int'(vid_rise);
      sync_dots  += int'(vid_rise && !vid_hsync);
      lit_dots   += int'(vid_rise && vid_visible);
      clock_high += int'(vid_clock);
      prev_h = vid_hsync;
      @(negedge I_clock);
    end while (!(prev_h && !vid_hsync));
    check_value("dots per line", 24'(dots), 24'd341);
    check_value("hsync dots", 24'(sync_dots), 24'd26);
    check_value("visible dots", 24'(lit_dots), 24'd256);
    check_value("vid_clock high cycles", 24'(clock_high), 24'd682);  // Two of every four

    wait_sync_fall(1'b1);
    prev_h = vid_hsync;
    prev_v = vid_vsync;
    @(negedge I_clock);
    while (!(prev_v && !vid_vsync))
    begin
      lines += int'(prev_h && !vid_hsync);  // One hsync fall per line
      prev_h = vid_hsync;
      prev_v = vid_vsync;
      @(negedge I_clock);
    end
    check_value("lines per frame", 24'(lines), 24'd262);
  endtask

  task automatic host_write(input logic [2:0] r, input logic [7:0] d,
                            input logic check_vid, input logic [13:0] exp_addr);
    @(posedge I_clock);
    host_addr  <= r;
    host_wdata <= d;
    host_wren  <= 1'b1;
    for (int i = 0; i < 3; i++)
    begin
      @(negedge I_clock);
      if (check_vid)
      begin
        check_value("vid_wren", 24'(vid_wren), 24'd1);
        check_value("vid_wdata", 24'(vid_wdata), 24'(d));
        if (i == 0)
          check_value("vid_addr", 24'(vid_addr), 24'(exp_addr));  // v steps later
      end
      @(posedge I_clock);
    end
    host_wren <= 1'b0;
    repeat (3) @(posedge I_clock);
  endtask

  task automatic host_read(input logic [2:0] r, input logic [7:0] vrd,
                           input logic [7:0] expected);
    @(posedge I_clock);
    host_addr <= r;
    vid_rdata <= vrd;
    host_rden <= 1'b1;
    @(negedge I_clock);
    check_value("host_rdata", 24'(host_rdata), 24'(expected));
    repeat (3) @(posedge I_clock);
    host_rden <= 1'b0;
    repeat (3) @(posedge I_clock);
  endtask

  task automatic run_operation(input logic [47:0] entry);
    logic [3:0]  op;
    logic [2:0]  r;
    logic [7:0]  d;
    logic [7:0]  vrd;
    logic [23:0] expected;
    op       = entry[47:44];
    r        = entry[42:40];
    d        = entry[39:32];
    vrd      = entry[31:24];
    expected = entry[23:0];
    case (op)
      4'd1: host_write(r, d, 1'b0, 14'd0);
      4'd2: host_read(r, vrd, expected[7:0]);
      4'd3:
      begin
        @(negedge I_clock);
        check_value("rgb", {red, green, blue}, expected);
      end
      4'd4: wait_sync_fall(1'b1);  // Vsync falls a line after the flag sets
      4'd5: host_write(r, d, 1'b1, expected[13:0]);
      4'd6:
      begin
        @(negedge I_clock);
        check_value("nmi", 24'(nmi), expected);
      end
      4'd7: measure_timing();
      default:
      begin
        error_count++;
        $display("Trace holds an unknown operation code %h", op);
      end
    endcase
  endtask

  initial
  begin
    I_reset    = 1'b0;
    host_addr  = 3'd0;
    host_rden  = 1'b0;
    host_wren  = 1'b0;
    host_wdata = 8'd0;
    vid_rdata  = 8'd0;
    for (int i = 0; i < trace_depth; i++)
      trace[i] = '0;  // Op 0 marks the end
    $readmemh("testbench/video_trace.txt", trace);
    if (trace[0][47:44] == 4'd0)
    begin
      error_count++;
      $display("The trace file holds no operations");
    end

    repeat (3) @(posedge I_clock);
    I_reset <= 1'b1;

    for (int i = 0; i < trace_depth && trace[i][47:44] != 4'd0; i++)
      run_operation(trace[i]);

    $display("Summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/video_trace.txt
// Hex word per line: op(1) reg(1) data(2) vid_rdata(2) expected(6)
// Ops: 1 write, 2 read, 3 rgb, 4 wait vblank, 5 memory write, 6 nmi level, 7 timing
7_0_00_00_000000  // Display timing
1_0_00_00_000000  // Step by 1
1_6_21_00_000000
1_6_08_00_000000  // Address 2108
5_7_5A_00_002108
5_7_A5_00_002109
1_0_04_00_000000  // Step by 32
5_7_33_00_00210A
5_7_44_00_00212A
1_6_02_00_000000
1_6_00_00_000000  // Address 0200
2_7_00_77_000000  // Stale buffer
2_7_00_99_000077
1_6_3F_00_000000
1_6_00_00_000000  // Palette 3F00
1_7_21_00_000000
1_6_3F_00_000000
1_6_11_00_000000
1_7_15_00_000000
1_6_3F_00_000000
1_6_10_00_000000
2_7_00_00_000021  // 3F10 mirrors 3F00
3_0_00_00_4C9AEC  // Backdrop colour 21
1_0_80_00_000000  // NMI enable
4_0_00_00_000000
6_0_00_00_000000
2_2_00_00_000080  // Vblank flag set
6_0_00_00_000001
2_2_00_00_000000

//--- sources.f
design/ppu_pkg.sv
design/pixel_timing.sv
design/host_regs.sv
design/palette_ram.sv
design/color_table.sv
design/video.sv
testbench/video_chk.sv
testbench/video_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert
TOP       = video_tb
FILELIST  = sources.f
OBJDIR    = obj_dir
PASS_MSG  = test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
